// File: hw/board_pkg.sv
// playfield size, cell codes, grid and row-count types, piece kinds
`default_nettype none

package board_pkg;

    // ----------------------------------------------------------------------
    // playfield size
    // ----------------------------------------------------------------------
    localparam int cols = 10;
    localparam int rows = 22;

    // ----------------------------------------------------------------------
    // cell codes
    // ----------------------------------------------------------------------
    // 0 empty, 1 locked, 2..7 falling piece by kind
    typedef logic [2:0] cell_t;

    localparam cell_t cell_empty  = 3'd0;
    localparam cell_t cell_locked = 3'd1;

    // falling code of a kind is its value plus 2
    typedef enum logic [2:0] {
        piece_o,
        piece_i,
        piece_s,
        piece_z,
        piece_l,
        piece_j
    } piece_kind_t;

    // whole board, indexed [column][row], row 0 at the top
    typedef cell_t [cols-1:0][rows-1:0] grid_t;

    // rows removed by one spawn, 0 to 4
    typedef logic [2:0] row_count_t;

endpackage

`default_nettype wire

// File: hw/input_pkg.sv
// keyboard scan codes and the decoded move command type
`default_nettype none

package input_pkg;

    // ----------------------------------------------------------------------
    // usb hid scan codes
    // ----------------------------------------------------------------------
    localparam logic [7:0] key_none  = 8'h00;
    // a
    localparam logic [7:0] key_left  = 8'h04;
    // d
    localparam logic [7:0] key_right = 8'h07;

    // one-cycle move request from the decoder
    typedef enum logic [1:0] {
        move_none,
        move_left,
        move_right
    } move_cmd_t;

endpackage

`default_nettype wire

// File: hw/key_decoder.sv
// press-edge detection on the keycode and mapping to a move command
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
    input  wire                  frame_clk,
    input  wire                  rst,
    input  wire [7:0]            keycode,
    output input_pkg::move_cmd_t cmd
);

    logic [7:0] prev_keycode;
    logic       press;

    always_ff @(posedge frame_clk) begin
        if (rst) begin
            prev_keycode <= input_pkg::key_none;
        end else begin
            prev_keycode <= keycode;
        end
    end

    // idle last cycle, something pressed now
    assign press = (prev_keycode == input_pkg::key_none) &&
                   (keycode != input_pkg::key_none);

    always_comb begin
        cmd = input_pkg::move_none;
        if (press) begin
            case (keycode)
                input_pkg::key_left:  cmd = input_pkg::move_left;
                input_pkg::key_right: cmd = input_pkg::move_right;
                default:              cmd = input_pkg::move_none;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/lock_clear_spawn.sv
// piece locking, full-row removal, piece sequence and spawn stamping
`timescale 1ns/1ps
`default_nettype none

module lock_clear_spawn (
    input  wire                   frame_clk,
    input  wire                   rst,
    input  wire board_pkg::grid_t grid,
    input  wire                   lock_req,
    output board_pkg::grid_t      spawn_grid,
    output board_pkg::row_count_t lines_cleared
);

    board_pkg::piece_kind_t next_kind;
    board_pkg::grid_t       work;
    board_pkg::row_count_t  cleared;
    board_pkg::cell_t       code;
    logic                   full;

    always_comb begin
        work    = grid;
        cleared = '0;

        // falling cells become locked
        for (int c = 0; c < board_pkg::cols; c++) begin
            for (int r = 0; r < board_pkg::rows; r++) begin
                if (work[c][r] > board_pkg::cell_locked) begin
                    work[c][r] = board_pkg::cell_locked;
                end
            end
        end

        // ------------------------------------------------------------------
        // row removal, top to bottom
        // ------------------------------------------------------------------
        for (int r = 0; r < board_pkg::rows; r++) begin
            full = 1'b1;
            for (int c = 0; c < board_pkg::cols; c++) begin
                if (work[c][r] != board_pkg::cell_locked) begin
                    full = 1'b0;
                end
            end
            if (full) begin
                // everything above row r drops by one
                for (int rr = board_pkg::rows - 1; rr > 0; rr--) begin
                    if (rr <= r) begin
                        for (int c = 0; c < board_pkg::cols; c++) begin
                            work[c][rr] = work[c][rr-1];
                        end
                    end
                end
                for (int c = 0; c < board_pkg::cols; c++) begin
                    work[c][0] = board_pkg::cell_empty;
                end
                cleared = cleared + 1'b1;
            end
        end

        // stamp the new piece at its spawn cells
        code = board_pkg::cell_t'(next_kind) + board_pkg::cell_t'(2);
        case (next_kind)
            board_pkg::piece_o: begin
                work[4][0] = code;
                work[5][0] = code;
                work[4][1] = code;
                work[5][1] = code;
            end
            board_pkg::piece_i: begin
                work[3][1] = code;
                work[4][1] = code;
                work[5][1] = code;
                work[6][1] = code;
            end
            board_pkg::piece_s: begin
                work[4][1] = code;
                work[5][1] = code;
                work[5][0] = code;
                work[6][0] = code;
            end
            board_pkg::piece_z: begin
                work[4][0] = code;
                work[5][0] = code;
                work[5][1] = code;
                work[6][1] = code;
            end
            board_pkg::piece_l: begin
                work[4][1] = code;
                work[5][1] = code;
                work[6][1] = code;
                work[6][0] = code;
            end
            default: begin
                // j piece
                work[4][0] = code;
                work[4][1] = code;
                work[5][1] = code;
                work[6][1] = code;
            end
        endcase

        spawn_grid = work;
    end

    // piece order o, i, s, z, l, j, then back to o
    always_ff @(posedge frame_clk) begin
        if (rst) begin
            next_kind     <= board_pkg::piece_o;
            lines_cleared <= '0;
        end else if (lock_req) begin
            lines_cleared <= cleared;
            if (next_kind == board_pkg::piece_j) begin
                next_kind <= board_pkg::piece_o;
            end else begin
                next_kind <= board_pkg::piece_kind_t'(next_kind + 3'd1);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/piece_mover.sv
// grid register, gravity timer, fall and shift checks, next-grid select
`timescale 1ns/1ps
`default_nettype none

module piece_mover #(
    parameter int DROP_PERIOD = 21
) (
    input  wire                       frame_clk,
    input  wire                       rst,
    input  wire input_pkg::move_cmd_t cmd,
    input  wire board_pkg::grid_t     spawn_grid,
    output board_pkg::grid_t          grid,
    output logic                      lock_req
);

    localparam int timer_w = $clog2(DROP_PERIOD);

    logic [timer_w-1:0] timer;
    logic               tick;
    logic               blank;
    logic               can_fall;
    logic               can_left;
    logic               can_right;
    board_pkg::grid_t   fall_grid;
    board_pkg::grid_t   left_grid;
    board_pkg::grid_t   right_grid;
    board_pkg::grid_t   next_grid;

    // ----------------------------------------------------------------------
    // grid scans
    // ----------------------------------------------------------------------
    function automatic logic is_falling(board_pkg::cell_t c);
        return c > board_pkg::cell_locked;
    endfunction

    // every falling cell has a free target at offset (dc, dr)
    function automatic logic can_move(board_pkg::grid_t g, int dc, int dr);
        logic ok;
        int   tc;
        int   tr;
        ok = 1'b1;
        for (int c = 0; c < board_pkg::cols; c++) begin
            for (int r = 0; r < board_pkg::rows; r++) begin
                tc = c + dc;
                tr = r + dr;
                if (is_falling(g[c][r])) begin
                    if (tc < 0 || tc >= board_pkg::cols ||
                        tr < 0 || tr >= board_pkg::rows) begin
                        ok = 1'b0;
                    end else if (g[tc][tr] != board_pkg::cell_empty &&
                                 !is_falling(g[tc][tr])) begin
                        ok = 1'b0;
                    end
                end
            end
        end
        return ok;
    endfunction

    // falling cells moved by (dc, dr) while locked cells stay put
    function automatic board_pkg::grid_t move_grid(board_pkg::grid_t g, int dc, int dr);
        board_pkg::grid_t res;
        int               sc;
        int               sr;
        for (int c = 0; c < board_pkg::cols; c++) begin
            for (int r = 0; r < board_pkg::rows; r++) begin
                sc = c - dc;
                sr = r - dr;
                if (g[c][r] == board_pkg::cell_locked) begin
                    res[c][r] = board_pkg::cell_locked;
                end else if (sc >= 0 && sc < board_pkg::cols &&
                             sr >= 0 && sr < board_pkg::rows &&
                             is_falling(g[sc][sr])) begin
                    res[c][r] = g[sc][sr];
                end else begin
                    res[c][r] = board_pkg::cell_empty;
                end
            end
        end
        return res;
    endfunction

    assign can_fall  = can_move(grid, 0, 1);
    assign can_left  = can_move(grid, -1, 0);
    assign can_right = can_move(grid, 1, 0);

    assign fall_grid  = move_grid(grid, 0, 1);
    assign left_grid  = move_grid(grid, -1, 0);
    assign right_grid = move_grid(grid, 1, 0);

    // ----------------------------------------------------------------------
    // action select in the order spawn, gravity, shift
    // ----------------------------------------------------------------------
    assign tick     = (timer == timer_w'(DROP_PERIOD - 1));
    assign lock_req = blank || (tick && !can_fall);

    always_comb begin
        if (lock_req) begin
            next_grid = spawn_grid;
        end else if (tick) begin
            next_grid = fall_grid;
        end else if (cmd == input_pkg::move_left && can_left) begin
            next_grid = left_grid;
        end else if (cmd == input_pkg::move_right && can_right) begin
            next_grid = right_grid;
        end else begin
            next_grid = grid;
        end
    end

    always_ff @(posedge frame_clk) begin
        if (rst) begin
            grid  <= '0;
            timer <= '0;
            blank <= 1'b1;
        end else begin
            grid  <= next_grid;
            // only the first cycle out of reset sees a blank board
            blank <= 1'b0;
            if (tick) begin
                timer <= '0;
            end else begin
                timer <= timer + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/tetris_board.sv
// top level joining key decoder, piece mover and lock/clear/spawn
`timescale 1ns/1ps
`default_nettype none

module tetris_board #(
    parameter int DROP_PERIOD = 21
) (
    input  wire                   frame_clk,
    input  wire                   rst,
    input  wire [7:0]             keycode,
    output board_pkg::grid_t      grid,
    output board_pkg::row_count_t lines_cleared
);

    input_pkg::move_cmd_t cmd;
    board_pkg::grid_t     spawn_grid;
    logic                 lock_req;

    // press edge to one-cycle move command
    key_decoder u_decoder (
        .frame_clk (frame_clk),
        .rst       (rst),
        .keycode   (keycode),
        .cmd       (cmd)
    );

    // board state and per-cycle action select
    piece_mover #(
        .DROP_PERIOD (DROP_PERIOD)
    ) u_mover (
        .frame_clk  (frame_clk),
        .rst        (rst),
        .cmd        (cmd),
        .spawn_grid (spawn_grid),
        .grid       (grid),
        .lock_req   (lock_req)
    );

    // grid after lock, row clear and spawn
    lock_clear_spawn u_spawn (
        .frame_clk     (frame_clk),
        .rst           (rst),
        .grid          (grid),
        .lock_req      (lock_req),
        .spawn_grid    (spawn_grid),
        .lines_cleared (lines_cleared)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the tetris_board testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tetris_board.f \
    --top-module tb_tetris_board -o sim_tetris_board > build.log 2>&1 \
    && ./obj_dir/sim_tetris_board +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "build or simulation ended with an error"

grep -q "^TEST PASSED$" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: testbench/tb_clock.sv
// testbench clock generator with a 4 ns period and a 16-cycle synchronous reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int RESET_CYCLES = 16
) (
    output logic frame_clk,
    output logic rst
);

    initial begin
        frame_clk = 1'b0;
        forever #2 frame_clk = ~frame_clk;
    end

    // release a little after the edge so the DUT sees it synchronously
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge frame_clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/tb_tetris_board.sv
// testbench with step table, board model, compare tasks and report
`timescale 1ns/1ps
`default_nettype none

module tb_tetris_board;

    localparam int drop_period = 6;
    localparam int wait_limit  = 4 * drop_period;

    typedef struct {
        logic [7:0]             key;
        int                     hold;
        board_pkg::piece_kind_t kind;
        int                     col;
        int                     row;
        int                     locked;
    } step_t;

    logic                   frame_clk;
    logic                   rst;
    logic [7:0]             keycode;
    board_pkg::grid_t       grid;
    board_pkg::row_count_t  lines_cleared;

    step_t                  steps[$];
    board_pkg::grid_t       locked_map;
    board_pkg::grid_t       prev_grid;
    board_pkg::row_count_t  exp_lines;
    board_pkg::piece_kind_t cur_kind;
    int                     cur_col;
    int                     cur_row;
    int                     check_errors;
    int                     steps_ok;
    int                     steps_bad;
    bit                     timed_out;

    tb_clock clk_gen (
        .frame_clk (frame_clk),
        .rst       (rst)
    );

    tetris_board #(
        .DROP_PERIOD (drop_period)
    ) UUT (
        .frame_clk     (frame_clk),
        .rst           (rst),
        .keycode       (keycode),
        .grid          (grid),
        .lines_cleared (lines_cleared)
    );

    bind tetris_board tetris_board_asserts u_asserts (
        .frame_clk     (frame_clk),
        .rst           (rst),
        .grid          (grid),
        .cmd           (cmd),
        .lines_cleared (lines_cleared)
    );

    // ----------------------------------------------------------------------
    // board model
    // ----------------------------------------------------------------------
    // cell offsets from the leftmost column and top row, by piece kind
    localparam int piece_dc[6][4] = '{
        '{0, 1, 0, 1},
        '{0, 1, 2, 3},
        '{0, 1, 1, 2},
        '{0, 1, 1, 2},
        '{0, 1, 2, 2},
        '{0, 0, 1, 2}
    };
    localparam int piece_dr[6][4] = '{
        '{0, 0, 1, 1},
        '{0, 0, 0, 0},
        '{1, 1, 0, 0},
        '{0, 0, 1, 1},
        '{1, 1, 1, 0},
        '{0, 1, 1, 1}
    };

    task automatic place_piece(inout board_pkg::grid_t g, input board_pkg::cell_t code);
        int k;
        k = int'(cur_kind);
        for (int i = 0; i < 4; i++) begin
            g[cur_col + piece_dc[k][i]][cur_row + piece_dr[k][i]] = code;
        end
    endtask

    // lock the current piece, then drop out full rows from the bottom up
    task automatic lock_piece(output int removed);
        int  r;
        bit  full;
        place_piece(locked_map, board_pkg::cell_locked);
        removed = 0;
        r = board_pkg::rows - 1;
        while (r >= 0) begin
            full = 1'b1;
            for (int c = 0; c < board_pkg::cols; c++) begin
                full = full && (locked_map[c][r] == board_pkg::cell_locked);
            end
            if (full) begin
                for (int rr = r; rr > 0; rr--) begin
                    for (int c = 0; c < board_pkg::cols; c++) begin
                        locked_map[c][rr] = locked_map[c][rr-1];
                    end
                end
                for (int c = 0; c < board_pkg::cols; c++) begin
                    locked_map[c][0] = board_pkg::cell_empty;
                end
                removed++;
            end else begin
                r--;
            end
        end
    endtask

    function automatic int count_locked(board_pkg::grid_t g);
        int n;
        n = 0;
        for (int c = 0; c < board_pkg::cols; c++) begin
            for (int r = 0; r < board_pkg::rows; r++) begin
                n += (g[c][r] == board_pkg::cell_locked) ? 1 : 0;
            end
        end
        return n;
    endfunction

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------
    task automatic check_grid(input board_pkg::grid_t got, input int exp_locked);
        board_pkg::grid_t exp;
        int               got_locked;
        exp = locked_map;
        place_piece(exp, board_pkg::cell_t'(int'(cur_kind) + 2));
        got_locked = count_locked(got);
        if (got !== exp) begin
            $display("FAILED grid: got %h expected %h", got, exp);
            check_errors++;
        end
        if (got_locked != exp_locked) begin
            $display("FAILED grid locked cells: got %h expected %h",
                     got_locked, exp_locked);
            check_errors++;
        end
    endtask

    task automatic check_lines(input board_pkg::row_count_t got,
                               input board_pkg::row_count_t exp);
        if (got !== exp) begin
            $display("FAILED lines_cleared: got %h expected %h", got, exp);
            check_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus table
    // ----------------------------------------------------------------------
    task automatic add_step(input logic [7:0] key, input int hold,
                            input board_pkg::piece_kind_t kind,
                            input int col, input int row, input int locked);
        step_t s;
        s = '{key, hold, kind, col, row, locked};
        steps.push_back(s);
    endtask

    task automatic add_drops(input board_pkg::piece_kind_t kind, input int col,
                             input int first_row, input int last_row, input int locked);
        for (int r = first_row; r <= last_row; r++) begin
            add_step(input_pkg::key_none, 0, kind, col, r, locked);
        end
    endtask

    task automatic build_table();
        // O piece moves once per press, stops at the right wall, then crosses to the left wall
        add_step(input_pkg::key_left, 3, board_pkg::piece_o, 3, 1, 0);
        add_step(input_pkg::key_left, 1, board_pkg::piece_o, 2, 2, 0);
        for (int i = 0; i < 6; i++) begin
            add_step(input_pkg::key_right, 1, board_pkg::piece_o, 3 + i, 3 + i, 0);
        end
        add_step(input_pkg::key_right, 1, board_pkg::piece_o, 8, 9, 0);
        for (int i = 0; i < 8; i++) begin
            add_step(input_pkg::key_left, 1, board_pkg::piece_o, 7 - i, 10 + i, 0);
        end
        add_drops(board_pkg::piece_o, 0, 18, 20, 0);
        // I lands on columns 4 to 7
        add_step(input_pkg::key_none, 0, board_pkg::piece_i, 3, 1, 4);
        add_step(input_pkg::key_right, 1, board_pkg::piece_i, 4, 2, 4);
        add_drops(board_pkg::piece_i, 4, 3, 21, 4);
        // S bottom on columns 2 and 3
        add_step(input_pkg::key_none, 0, board_pkg::piece_s, 4, 0, 8);
        add_step(input_pkg::key_left, 1, board_pkg::piece_s, 3, 1, 8);
        add_step(input_pkg::key_left, 1, board_pkg::piece_s, 2, 2, 8);
        add_drops(board_pkg::piece_s, 2, 3, 20, 8);
        // Z bottom on columns 8 and 9 completes row 21
        add_step(input_pkg::key_none, 0, board_pkg::piece_z, 4, 0, 12);
        for (int i = 0; i < 3; i++) begin
            add_step(input_pkg::key_right, 1, board_pkg::piece_z, 5 + i, 1 + i, 12);
        end
        add_drops(board_pkg::piece_z, 7, 4, 20, 12);
        add_step(input_pkg::key_none, 0, board_pkg::piece_l, 4, 0, 6);
        add_drops(board_pkg::piece_l, 4, 1, 3, 6);
    endtask

    // next grid change, which is a gravity fall or a spawn
    task automatic wait_board_change(output int cycles, output bit ok);
        cycles = 0;
        do begin
            @(posedge frame_clk);
            #1;
            cycles++;
        end while (grid == prev_grid && cycles < wait_limit);
        ok = (grid != prev_grid);
    endtask

    initial begin
        step_t s;
        int    cycles;
        int    removed;
        int    errs_before;
        bit    ok;
        bit    prev_keyless;

        keycode      = input_pkg::key_none;
        locked_map   = '0;
        prev_grid    = '0;
        exp_lines    = '0;
        check_errors = 0;
        steps_ok     = 0;
        steps_bad    = 0;
        timed_out    = 1'b0;
        prev_keyless = 1'b0;
        build_table();

        // first spawn right after reset
        cycles = 0;
        while (rst !== 1'b0 && cycles < 100) begin
            @(posedge frame_clk);
            cycles++;
        end
        wait_board_change(cycles, ok);
        if (!ok || rst) begin
            $display("timeout: no piece spawned after reset");
            timed_out = 1'b1;
        end else begin
            cur_kind = board_pkg::piece_o;
            cur_col  = 4;
            cur_row  = 0;
            check_grid(grid, 0);
            check_lines(lines_cleared, exp_lines);
            $display("reset spawn: %s", (check_errors == 0) ? "ok" : "failed");
            prev_grid = grid;
        end

        for (int i = 0; i < steps.size() && !timed_out; i++) begin
            s = steps[i];
            errs_before = check_errors;
            wait_board_change(cycles, ok);
            if (!ok) begin
                $display("timeout: board did not change before step %0d", i);
                timed_out = 1'b1;
                break;
            end
            if (s.kind != cur_kind) begin
                lock_piece(removed);
                exp_lines = board_pkg::row_count_t'(removed);
            end
            if (s.key != input_pkg::key_none) begin
                keycode = s.key;
                repeat (s.hold) begin
                    @(posedge frame_clk);
                    #1;
                end
                keycode = input_pkg::key_none;
                @(posedge frame_clk);
                #1;
            end else if (prev_keyless && s.kind == cur_kind && cycles != drop_period) begin
                $display("step %0d: gravity came after %0d cycles instead of %0d",
                         i, cycles, drop_period);
                check_errors++;
            end
            cur_kind = s.kind;
            cur_col  = s.col;
            cur_row  = s.row;
            check_grid(grid, s.locked);
            check_lines(lines_cleared, exp_lines);
            prev_grid    = grid;
            prev_keyless = (s.key == input_pkg::key_none);
            if (check_errors == errs_before) begin
                steps_ok++;
                $display("step %0d: ok", i);
            end else begin
                steps_bad++;
                $display("step %0d: failed", i);
            end
        end

        $display("steps passed %0d, failed %0d, check errors %0d, assertion errors %0d",
                 steps_ok, steps_bad, check_errors, UUT.u_asserts.assert_errors);
        if (!timed_out && check_errors == 0 && UUT.u_asserts.assert_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tetris_board_asserts.sv
// bound assertions on the falling piece size, the move command pulse and the cleared-row count
`timescale 1ns/1ps
`default_nettype none

module tetris_board_asserts (
    input wire                        frame_clk,
    input wire                        rst,
    input wire board_pkg::grid_t      grid,
    input wire input_pkg::move_cmd_t  cmd,
    input wire board_pkg::row_count_t lines_cleared
);

    int assert_errors = 0;

    function automatic int falling_count(board_pkg::grid_t g);
        int n;
        n = 0;
        for (int c = 0; c < board_pkg::cols; c++) begin
            for (int r = 0; r < board_pkg::rows; r++) begin
                if (g[c][r] > board_pkg::cell_locked) begin
                    n++;
                end
            end
        end
        return n;
    endfunction

    // no piece before the first spawn, four cells after it
    a_piece_cells: assert property (@(posedge frame_clk) disable iff (rst)
        falling_count(grid) == 0 || falling_count(grid) == 4)
        else begin
            $error("falling piece does not have four cells");
            assert_errors++;
        end

    // a press gives a single-cycle command
    a_cmd_pulse: assert property (@(posedge frame_clk) disable iff (rst)
        cmd != input_pkg::move_none |=> cmd == input_pkg::move_none)
        else begin
            $error("move command held for two cycles");
            assert_errors++;
        end

    a_lines_max: assert property (@(posedge frame_clk) disable iff (rst)
        lines_cleared <= 3'd4)
        else begin
            $error("lines_cleared above 4");
            assert_errors++;
        end

endmodule

`default_nettype wire

// File: tetris_board.f
hw/board_pkg.sv
hw/input_pkg.sv
hw/key_decoder.sv
hw/piece_mover.sv
hw/lock_clear_spawn.sv
hw/tetris_board.sv
testbench/tb_clock.sv
testbench/tetris_board_asserts.sv
testbench/tb_tetris_board.sv
